//--- fconv.f
logic/fconv_pkg.sv
logic/fconv_pipe_reg.sv
logic/fconv_unpack.sv
logic/fconv_round.sv
logic/fconv_top.sv
sim/fconv_assert.sv
sim/fconv_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the fconv testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 -Mdir obj_dir \
    --top-module fconv_tb -f fconv.f; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vfconv_tb +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0

//--- sim/fconv_tb.sv
// testbench for the fp32 conversion unit: directed and seeded random
// operations with random output back-pressure, checked by the bound assertions
`timescale 1ns/1ps

module fconv_tb
  import fconv_pkg::*;
();

  localparam int WAIT_MAX = 200;  // cycles per wait
  localparam int N_RANDOM = 300;

  logic            clk, rst, in_valid, in_ready, out_valid, out_ready;
  fconv_op_e       op;
  roundmode_e      rm;
  logic [FLEN-1:0] rs, result;
  fflags_t         fflags;
  logic            bp_en;      // random output stalls
  int              n_timeout;
  int              waited;

  fconv_top DUT (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .i_op        (op),
    .i_rm        (rm),
    .i_rs        (rs),
    .o_out_valid (out_valid),
    .i_out_ready (out_ready),
    .o_result    (result),
    .o_fflags    (fflags)
  );

  bind fconv_top fconv_assert u_chk (
    .i_clk(i_clk), .i_rst(i_rst), .i_in_valid(i_in_valid), .i_in_ready(o_in_ready),
    .i_op(i_op), .i_rm(i_rm), .i_rs(i_rs), .i_out_valid(o_out_valid),
    .i_out_ready(i_out_ready), .i_result(o_result), .i_fflags(o_fflags)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    #1;
    out_ready = bp_en ? 1'($urandom % 3 != 0) : 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  // entered 1 ns after an edge, leaves 1 ns after the accepting edge
  task automatic send(input fconv_op_e o, input roundmode_e r, input logic [31:0] v);
    int cnt;
    cnt      = 0;
    in_valid = 1'b1;
    op       = o;
    rm       = r;
    rs       = v;
    @(negedge clk);
    while (!in_ready && cnt < WAIT_MAX) begin
      @(negedge clk);
      cnt++;
    end
    if (!in_ready) begin
      n_timeout++;
      $display("timeout: operation not accepted within %0d cycles", WAIT_MAX);
    end
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] pick_operand();
    logic        s;
    logic [31:0] v;
    logic [31:0] halves [4];
    halves = '{32'h3F000000, 32'h3FC00000, 32'h40200000, 32'h40600000};  // 0.5 .. 3.5
    s = 1'($urandom);
    v = $urandom % 2048;
    case ($urandom % 6)
      0:       return s ? (~v + 32'd1) : v;                        // small ints
      1:       return {s, halves[2'($urandom)][30:0]};             // exact halves
      2:       return {s, 8'(120 + $urandom % 41), 23'($urandom)};  // near the int range
      3:       return {s, 8'hFF, 23'($urandom | 32'd1)};           // nans
      4:       return {s, 8'hFF, 23'b0};                           // infinities
      default: return {1'b1, 31'($urandom)};                       // negatives
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(92));
    clk       = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    op        = OP_FMV_X_W;
    rm        = RM_RNE;
    rs        = '0;
    out_ready = 1'b1;
    bp_en     = 1'b0;
    n_timeout = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // directed, output always ready
    send(OP_FMV_X_W, RM_RNE, 32'hDEADBEEF);
    send(OP_FMV_W_X, RM_RUP, 32'h7FC00001);
    send(OP_FCVT_S_W, RM_RNE, 32'h0);
    send(OP_FCVT_S_W, RM_RNE, 32'hFFFFFFFF);  // -1
    send(OP_FCVT_S_W, RM_RNE, 32'h80000000);
    send(OP_FCVT_S_WU, RM_RNE, 32'hFFFFFFFF);
    send(OP_FCVT_S_WU, RM_RTZ, 32'h00FFFFFF);  // widest exact
    send(OP_FCVT_W_S, RM_RNE, 32'h7FC00000);   // qnan
    send(OP_FCVT_WU_S, RM_RNE, 32'hFF800001);  // negative snan
    send(OP_FCVT_W_S, RM_RNE, 32'hFF800000);   // -inf
    send(OP_FCVT_WU_S, RM_RNE, 32'h7F800000);  // +inf
    send(OP_FCVT_W_S, RM_RNE, 32'h4F000000);   // 2^31, too big
    send(OP_FCVT_W_S, RM_RNE, 32'hCF000000);   // -2^31 fits
    send(OP_FCVT_WU_S, RM_RNE, 32'h4F800000);  // 2^32
    send(OP_FCVT_WU_S, RM_RNE, 32'hBF800000);  // -1.0 unsigned
    send(OP_FCVT_W_S, RM_RNE, 32'h80000000);   // -0.0
    for (int r = 0; r < 5; r++) begin
      send(OP_FCVT_W_S, roundmode_e'(3'(r)), 32'h40200000);   // 2.5
      send(OP_FCVT_W_S, roundmode_e'(3'(r)), 32'hC0200000);   // -2.5
      send(OP_FCVT_W_S, roundmode_e'(3'(r)), 32'h40600000);   // 3.5
      send(OP_FCVT_WU_S, roundmode_e'(3'(r)), 32'hBE800000);  // -0.25
      send(OP_FCVT_WU_S, roundmode_e'(3'(r)), 32'h00000001);  // smallest subnormal
      send(OP_FCVT_S_W, roundmode_e'(3'(r)), 32'h01000001);   // tie, even kept
      send(OP_FCVT_S_W, roundmode_e'(3'(r)), 32'hFEFFFFFD);   // negative tie, odd kept
    end

    // random, with output stalls
    bp_en = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      send(fconv_op_e'(3'($urandom % 6)), roundmode_e'(3'($urandom % 5)), pick_operand());
      if ($urandom % 8 == 0) begin
        in_valid = 1'b0;  // idle gap
        @(posedge clk);
        #1;
      end
    end
    in_valid = 1'b0;
    bp_en    = 1'b0;

    waited = 0;
    while (DUT.u_chk.pending != 0 && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (DUT.u_chk.pending != 0) begin
      n_timeout++;
      $display("timeout: %0d operations never returned", DUT.u_chk.pending);
    end
    repeat (2) @(posedge clk);

    $display("errors: %0d assertion failures, %0d timeouts", DUT.u_chk.n_err, n_timeout);
    if (DUT.u_chk.n_err == 0 && n_timeout == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #200000;
    $display("watchdog: simulation did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- sim/fconv_assert.sv
// bound checker for the conversion unit: in-order request queue,
// conversion reference model and handshake properties
`timescale 1ns/1ps

module fconv_assert
  import fconv_pkg::*;
(
  input logic            i_clk,
  input logic            i_rst,
  input logic            i_in_valid,
  input logic            i_in_ready,
  input fconv_op_e       i_op,
  input roundmode_e      i_rm,
  input logic [FLEN-1:0] i_rs,
  input logic            i_out_valid,
  input logic            i_out_ready,
  input logic [FLEN-1:0] i_result,
  input fflags_t         i_fflags
);

  typedef struct packed {
    fconv_op_e       op;
    roundmode_e      rm;
    logic [FLEN-1:0] rs;
  } req_t;

  int n_err = 0;  // failed checks, read by the testbench
  int pending;    // accepted, not yet returned

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////
  // rem and half measured in units of the discarded field
  function automatic logic inc_needed(input roundmode_e rm, input logic neg, input logic odd,
                                      input logic [63:0] rem, input logic [63:0] half);
    case (rm)
      RM_RNE:  return (rem > half) || ((rem == half) && odd);
      RM_RDN:  return neg && (rem != '0);
      RM_RUP:  return !neg && (rem != '0);
      RM_RMM:  return rem >= half;  // half is never zero
      default: return 1'b0;         // rtz
    endcase
  endfunction

  // integer -> fp32, returns {result, nv, nx}
  function automatic logic [FLEN+1:0] ref_to_float(input logic is_signed, input roundmode_e rm,
                                                   input logic [31:0] rs);
    logic        neg;
    logic [31:0] a;
    logic [63:0] mag, kept, rem, half;
    int          p;
    neg = is_signed && rs[31];
    a   = neg ? (~rs + 32'd1) : rs;
    mag = {32'b0, a};
    if (mag == '0) return '0;
    p = 0;
    for (int i = 0; i < 32; i++) if (mag[i]) p = i;  // leading one
    if (p <= 23) begin
      kept = mag << (23 - p);  // exact
      rem  = '0;
      half = 64'd1;
    end else begin
      kept = mag >> (p - 23);
      rem  = mag & ((64'd1 << (p - 23)) - 64'd1);
      half = 64'd1 << (p - 24);
    end
    kept = kept + 64'(inc_needed(rm, neg, kept[0], rem, half));
    if (kept[24]) begin
      kept = kept >> 1;  // carried into a new binade
      p    = p + 1;
    end
    return {neg, 8'(127 + p), kept[22:0], 1'b0, rem != '0};
  endfunction

  // fp32 -> integer, returns {result, nv, nx}
  function automatic logic [FLEN+1:0] ref_to_int(input logic is_uns, input roundmode_e rm,
                                                 input logic [31:0] rs);
    logic        neg;
    logic [7:0]  e;
    logic [31:0] v;
    logic [63:0] m, ip, rem, half;
    int          sh;
    neg = rs[31];
    e   = rs[30:23];
    m   = {40'b0, e != 8'h00, rs[22:0]};
    if (e == 8'hFF && rs[22:0] != '0) return {is_uns ? 32'hFFFFFFFF : 32'h7FFFFFFF, 2'b10};
    if (rs[30:0] == '0) return '0;
    sh   = ((e == 8'h00) ? 1 : int'(e)) - 150;  // value is m * 2^sh
    rem  = '0;
    half = 64'd1;
    if (e == 8'hFF || sh > 32) begin
      ip = 64'd1 << 40;  // far beyond any limit
    end else if (sh >= 0) begin
      ip = m << sh;
    end else if (-sh > 25) begin
      ip   = '0;  // nonzero, below one half
      rem  = 64'd1;
      half = 64'd2;
    end else begin
      ip   = m >> (-sh);
      rem  = m & ((64'd1 << (-sh)) - 64'd1);
      half = 64'd1 << (-sh - 1);
    end
    ip = ip + 64'(inc_needed(rm, neg, ip[0], rem, half));
    if (is_uns) begin
      if (neg && ip != '0) return {32'h0, 2'b10};
      if (ip > 64'hFFFFFFFF) return {32'hFFFFFFFF, 2'b10};
      return {ip[31:0], 1'b0, rem != '0};
    end
    if (neg) begin
      if (ip > 64'h80000000) return {32'h80000000, 2'b10};
      v = ~ip[31:0] + 32'd1;
      return {v, 1'b0, rem != '0};
    end
    if (ip > 64'h7FFFFFFF) return {32'h7FFFFFFF, 2'b10};
    return {ip[31:0], 1'b0, rem != '0};
  endfunction

  function automatic logic [FLEN+1:0] ref_model(input req_t r);
    case (r.op)
      OP_FCVT_S_W:  return ref_to_float(1'b1, r.rm, r.rs);
      OP_FCVT_S_WU: return ref_to_float(1'b0, r.rm, r.rs);
      OP_FCVT_W_S:  return ref_to_int(1'b0, r.rm, r.rs);
      OP_FCVT_WU_S: return ref_to_int(1'b1, r.rm, r.rs);
      default:      return {r.rs, 2'b00};  // fmv, plain bit move
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // in-order request queue
  ////////////////////////////////////////////////////////////////////////////
  req_t            ring [8];  // two in flight at most
  logic [2:0]      wr_ptr, rd_ptr;
  logic            in_xfer, out_xfer;
  logic [FLEN+1:0] exp_val;   // {result, nv, nx} for the head

  assign in_xfer  = i_in_valid & i_in_ready;
  assign out_xfer = i_out_valid & i_out_ready;

  always_comb exp_val = ref_model(ring[rd_ptr]);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      pending <= 0;
    end else begin
      if (in_xfer) begin
        ring[wr_ptr] <= {i_op, i_rm, i_rs};
        wr_ptr       <= wr_ptr + 3'd1;
      end
      if (out_xfer) rd_ptr <= rd_ptr + 3'd1;  // pop head
      pending <= pending + int'(in_xfer) - int'(out_xfer);
    end
  end

  a_result: assert property (@(posedge i_clk) disable iff (i_rst)
    out_xfer |-> i_result == exp_val[FLEN+1:2])
    else begin
      n_err++;
      $error("** Error o_result: expected %08h, got %08h",
             $sampled(exp_val[FLEN+1:2]), $sampled(i_result));
    end

  a_fflags: assert property (@(posedge i_clk) disable iff (i_rst)
    out_xfer |-> i_fflags == exp_val[1:0])
    else begin
      n_err++;
      $error("** Error o_fflags: expected %h, got %h", $sampled(exp_val[1:0]), $sampled(i_fflags));
    end

  a_no_extra: assert property (@(posedge i_clk) disable iff (i_rst) out_xfer |-> pending != 0)
    else begin
      n_err++;
      $error("output returned with no operation outstanding");
    end

  // empty pipeline right after reset
  a_reset: assert property (@(posedge i_clk) $fell(i_rst) |-> !i_out_valid && i_in_ready)
    else begin
      n_err++;
      $error("pipeline not empty in the first cycle after reset");
    end

  // stalled output holds its data
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_result) && $stable(i_fflags))
    else begin
      n_err++;
      $error("output dropped or changed while stalled");
    end

  a_latency: assert property (@(posedge i_clk) disable iff (i_rst)
    $past(in_xfer) && i_out_ready |=> i_out_valid)
    else begin
      n_err++;
      $error("output not valid two cycles after an accepted input");
    end

endmodule

//--- logic/fconv_top.sv
// fp32 conversion unit top: unpack, stage register, round, output register
`timescale 1ns/1ps

module fconv_top
  import fconv_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst,
  // request
  input  logic            i_in_valid,
  output logic            o_in_ready,
  input  fconv_op_e       i_op,
  input  roundmode_e      i_rm,
  input  logic [FLEN-1:0] i_rs,
  // response
  output logic            o_out_valid,
  input  logic            i_out_ready,
  output logic [FLEN-1:0] o_result,
  output fflags_t         o_fflags
);

  unpacked_t unp_d, unp_q;
  result_t   res_d, res_q;
  logic      s1_valid, s1_ready;

  fconv_unpack u_unpack (
    .i_op  (i_op),
    .i_rm  (i_rm),
    .i_rs  (i_rs),
    .o_unp (unp_d)
  );

  // stage 1, unpacked operand
  fconv_pipe_reg #(.payload_t(unpacked_t)) u_s1 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_in_valid),
    .o_ready (o_in_ready),
    .i_data  (unp_d),
    .o_valid (s1_valid),
    .i_ready (s1_ready),
    .o_data  (unp_q)
  );

  fconv_round u_round (
    .i_unp (unp_q),
    .o_res (res_d)
  );

  // stage 2, packed result
  fconv_pipe_reg #(.payload_t(result_t)) u_s2 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (s1_valid),
    .o_ready (s1_ready),
    .i_data  (res_d),
    .o_valid (o_out_valid),
    .i_ready (i_out_ready),
    .o_data  (res_q)
  );

  assign o_result = res_q.result;
  assign o_fflags = res_q.fflags;

endmodule

//--- logic/fconv_round.sv
// round and pack stage: fmv passthrough, int->float and float->int
// rounding, saturation of integer special cases, result flags
`timescale 1ns/1ps

module fconv_round
  import fconv_pkg::*;
(
  input  unpacked_t i_unp,
  output result_t   o_res
);

  localparam logic signed [EXP_IW-1:0] EXP_TOP  = EXP_IW'(FLEN - 1);  // 2^31
  localparam logic signed [EXP_IW-1:0] EXP_HALF = -EXP_IW'(1);        // 0.5

  function automatic logic round_up(input roundmode_e rm, input logic sign,
                                    input logic lsb, input logic rb, input logic sb);
    case (rm)
      RM_RNE:  return rb & (sb | lsb);  // ties to even
      RM_RTZ:  return 1'b0;
      RM_RDN:  return (rb | sb) & sign;
      RM_RUP:  return (rb | sb) & ~sign;
      RM_RMM:  return rb;               // ties away
      default: return 1'b0;
    endcase
  endfunction

  logic dst_is_int, cvt_uint, nan_in;
  logic signed [EXP_IW-1:0] exp_s;

  assign dst_is_int = (i_unp.op == OP_FCVT_W_S) | (i_unp.op == OP_FCVT_WU_S);
  assign cvt_uint   = (i_unp.op == OP_FCVT_WU_S);
  assign nan_in     = i_unp.is_nan;  // quiet and signalling alike
  assign exp_s      = i_unp.exp;

  ////////////////////////////////////////////////////////////////////////////
  // float -> int alignment
  ////////////////////////////////////////////////////////////////////////////
  logic [5:0]      shamt;
  logic [2*FLEN:0] int_shifted;  // int part, round bit, sticky field
  logic            of_before;

  always_comb begin
    if (exp_s < EXP_HALF) shamt = 6'd33;  // everything into sticky
    else if (exp_s > EXP_TOP) shamt = 6'd0;
    else shamt = 6'(EXP_TOP - exp_s);
  end

  assign int_shifted = {i_unp.man, {(FLEN+1){1'b0}}} >> shamt;

  // -2^31 is the only signed value with exponent 31
  assign of_before = (exp_s > EXP_TOP) |
                     ((exp_s == EXP_TOP) & ~cvt_uint &
                      ~(i_unp.sign & (i_unp.man[FLEN-2:0] == '0)));

  ////////////////////////////////////////////////////////////////////////////
  // shared rounder
  ////////////////////////////////////////////////////////////////////////////
  logic signed [EXP_IW-1:0] fp_exp_b;
  logic [FLEN-1:0] fp_pre, pre_abs;
  logic            rb, sb;
  logic [FLEN:0]   rounded;  // extra bit catches the unsigned carry

  assign fp_exp_b = exp_s + EXP_IW'(BIAS);  // rebias, 127..158
  assign fp_pre   = {1'b0, fp_exp_b[EXP_W-1:0], i_unp.man[FLEN-2 -: MAN_W]};  // drop hidden 1

  assign pre_abs = dst_is_int ? int_shifted[2*FLEN:FLEN+1] : fp_pre;
  assign rb      = dst_is_int ? int_shifted[FLEN] : i_unp.man[FLEN-2-MAN_W];
  assign sb      = dst_is_int ? |int_shifted[FLEN-1:0] : |i_unp.man[FLEN-3-MAN_W:0];

  // mantissa carry ripples into the exponent for the float case
  assign rounded = {1'b0, pre_abs} +
                   (FLEN+1)'(round_up(i_unp.rm, i_unp.sign, pre_abs[0], rb, sb));

  ////////////////////////////////////////////////////////////////////////////
  // integer result and special cases
  ////////////////////////////////////////////////////////////////////////////
  logic [FLEN-1:0] rnd_mag, int_res, int_sat;
  logic            of_after, neg_uint, int_special;

  assign rnd_mag  = rounded[FLEN-1:0];
  assign int_res  = i_unp.sign ? (~rnd_mag + 1'b1) : rnd_mag;
  // only positives can round past the top
  assign of_after = ~i_unp.sign & (cvt_uint ? rounded[FLEN] : rounded[FLEN-1]);
  assign neg_uint = i_unp.sign & cvt_uint & (rnd_mag != '0);

  assign int_special = nan_in | i_unp.is_inf | of_before | of_after | neg_uint;

  always_comb begin
    int_sat = {cvt_uint, {(FLEN-1){1'b1}}};          // 7fffffff or ffffffff
    if (i_unp.sign && !nan_in) int_sat = ~int_sat;  // 80000000 or 0
  end

  ////////////////////////////////////////////////////////////////////////////
  // result select
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    o_res = '0;
    case (i_unp.op)
      OP_FMV_X_W, OP_FMV_W_X: begin
        o_res.result = i_unp.raw;  // bit move, no flags
      end
      OP_FCVT_S_W, OP_FCVT_S_WU: begin
        o_res.result    = i_unp.man_zero ? '0 : {i_unp.sign, rounded[FLEN-2:0]};
        o_res.fflags.nx = rb | sb;
      end
      OP_FCVT_W_S, OP_FCVT_WU_S: begin
        if (i_unp.is_zero) begin
          o_res.result = '0;  // +-0 lands on integer zero
        end else if (int_special) begin
          o_res.result    = int_sat;
          o_res.fflags.nv = 1'b1;
        end else begin
          o_res.result    = int_res;
          o_res.fflags.nx = rb | sb;
        end
      end
      default: o_res = '0;
    endcase
  end

endmodule

//--- logic/fconv_unpack.sv
// operand unpack: int magnitude or float fields, classification
// leading-zero count and normalization into the common form
`timescale 1ns/1ps

module fconv_unpack
  import fconv_pkg::*;
(
  input  fconv_op_e        i_op,
  input  roundmode_e       i_rm,
  input  logic [FLEN-1:0]  i_rs,
  output unpacked_t        o_unp
);

  localparam int LZ_W = $clog2(FLEN);

  ////////////////////////////////////////////////////////////////////////////
  // source decode
  ////////////////////////////////////////////////////////////////////////////
  logic src_is_int;
  logic src_unsigned;
  logic int_sign;
  logic [FLEN-1:0] int_mag;

  assign src_is_int   = (i_op == OP_FCVT_S_W) | (i_op == OP_FCVT_S_WU);
  assign src_unsigned = (i_op == OP_FCVT_S_WU);

  assign int_sign = src_is_int & ~src_unsigned & i_rs[FLEN-1];
  assign int_mag  = int_sign ? (~i_rs + 1'b1) : i_rs;  // magnitude of negative

  // float fields
  logic [EXP_W-1:0] exp_f;
  logic [MAN_W-1:0] man_f;
  logic exp_zero, exp_ones, frac_zero;
  logic is_normal, is_sub;

  assign exp_f     = i_rs[FLEN-2 -: EXP_W];
  assign man_f     = i_rs[MAN_W-1:0];
  assign exp_zero  = (exp_f == '0);
  assign exp_ones  = (exp_f == '1);
  assign frac_zero = (man_f == '0);
  assign is_normal = ~exp_zero & ~exp_ones;
  assign is_sub    = exp_zero & ~frac_zero;

  logic [FLEN-1:0] fp_man;
  logic [FLEN-1:0] man_ext;

  assign fp_man  = {{(FLEN-MAN_W-1){1'b0}}, is_normal, man_f};  // hidden bit added
  assign man_ext = src_is_int ? int_mag : fp_man;

  ////////////////////////////////////////////////////////////////////////////
  // normalize
  ////////////////////////////////////////////////////////////////////////////
  logic [LZ_W-1:0] lz_cnt;

  // last hit wins, so highest set bit
  always_comb begin
    lz_cnt = '0;
    for (int i = 0; i < FLEN; i++) begin
      if (man_ext[i]) lz_cnt = LZ_W'(FLEN - 1 - i);
    end
  end

  logic signed [EXP_IW-1:0] exp_b;  // biased, widened
  logic signed [EXP_IW-1:0] lz_s;
  logic signed [EXP_IW-1:0] fp_exp;
  logic signed [EXP_IW-1:0] int_exp;

  assign exp_b   = signed'(EXP_IW'(exp_f));
  assign lz_s    = signed'(EXP_IW'(lz_cnt));
  // subnormals use exponent 1, width offset of 8 for the lzc
  assign fp_exp  = exp_b + EXP_IW'(is_sub) - EXP_IW'(BIAS) - lz_s + EXP_IW'(FLEN - 1 - MAN_W);
  assign int_exp = EXP_IW'(FLEN - 1) - lz_s;

  always_comb begin
    o_unp          = '0;
    o_unp.op       = i_op;
    o_unp.rm       = i_rm;
    o_unp.raw      = i_rs;
    o_unp.sign     = src_is_int ? int_sign : i_rs[FLEN-1];
    o_unp.exp      = src_is_int ? int_exp : fp_exp;
    o_unp.man      = man_ext << lz_cnt;  // leading one to msb
    o_unp.man_zero = (man_ext == '0);
    o_unp.is_zero  = exp_zero & frac_zero;
    o_unp.is_inf   = exp_ones & frac_zero;
    o_unp.is_nan   = exp_ones & ~frac_zero;
    o_unp.is_snan  = exp_ones & ~frac_zero & ~man_f[MAN_W-1];  // quiet bit clear
  end

endmodule

//--- logic/fconv_pipe_reg.sv
// valid/ready register slice, generic over its payload type
`timescale 1ns/1ps

module fconv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_clk,
  input  logic     i_rst,
  // upstream side
  input  logic     i_valid,
  output logic     o_ready,
  input  payload_t i_data,
  // downstream side
  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data
);

  // free slot, or the held item leaves this cycle
  assign o_ready = ~o_valid | i_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;  // refill or go empty
    end
  end

  // payload only, no reset
  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_data <= i_data;
    end
  end

endmodule

//--- logic/fconv_pkg.sv
// fp32 conversion constants, operation and rounding enums
// flag type and the two pipeline stage payloads
package fconv_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // fp32 format
  ////////////////////////////////////////////////////////////////////////////
  parameter int FLEN   = 32;  // operand width
  parameter int EXP_W  = 8;   // exponent field
  parameter int MAN_W  = 23;  // stored mantissa, no hidden bit
  parameter int BIAS   = 127;
  // internal exponent, signed
  // must reach the smallest subnormal (-149) and 31 for integers
  parameter int EXP_IW = 10;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    OP_FMV_X_W   = 3'd0,  // float bits -> int reg
    OP_FMV_W_X   = 3'd1,  // int reg -> float bits
    OP_FCVT_S_W  = 3'd2,  // signed int -> float
    OP_FCVT_S_WU = 3'd3,  // unsigned int -> float
    OP_FCVT_W_S  = 3'd4,  // float -> signed int
    OP_FCVT_WU_S = 3'd5   // float -> unsigned int
  } fconv_op_e;

  // riscv frm encoding
  typedef enum logic [2:0] {
    RM_RNE = 3'b000,  // nearest, ties to even
    RM_RTZ = 3'b001,  // toward zero
    RM_RDN = 3'b010,  // toward -inf
    RM_RUP = 3'b011,  // toward +inf
    RM_RMM = 3'b100   // nearest, ties away
  } roundmode_e;

  typedef struct packed {
    logic nv;  // invalid
    logic nx;  // inexact
  } fflags_t;

  ////////////////////////////////////////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////////////////////////////////////////
  // unpack -> round
  typedef struct packed {
    fconv_op_e                op;
    roundmode_e               rm;
    logic [FLEN-1:0]          raw;       // operand as received, for fmv
    logic                     sign;
    logic signed [EXP_IW-1:0] exp;       // unbiased
    logic [FLEN-1:0]          man;       // leading one at bit 31
    logic                     man_zero;  // nothing to normalize
    logic                     is_zero;   // float +-0
    logic                     is_inf;
    logic                     is_nan;    // any nan
    logic                     is_snan;
  } unpacked_t;

  // round -> output
  typedef struct packed {
    logic [FLEN-1:0] result;
    fflags_t         fflags;
  } result_t;

endpackage
